// File: logic/rhythm_pkg.sv
`default_nettype none

package rhythm_pkg;

    // window and slice memory share one depth
    localparam int NUM_SLOTS = 12;

    // depth units removed per game tick
    localparam int Z_STEP = 16;

    // 12-bit rgb, 4 bits per channel
    localparam logic [11:0] BG_COLOR = 12'h000;
    localparam logic [11:0] BLUE_RGB = 12'h00F;
    localparam logic [11:0] RED_RGB  = 12'hF00;
    localparam logic [11:0] MARK_RGB = 12'hFFF;

    typedef enum logic [2:0] {
        dir_up,
        dir_right,
        dir_down,
        dir_left,
        dir_any         // cut from any side, marker is a center dot
    } dir_t;

    typedef enum logic {
        color_blue,
        color_red
    } color_t;

    typedef struct packed {
        logic [17:0] game_time;
        logic [10:0] x;
        logic [9:0]  y;
    } pixel_t;

    typedef struct packed {
        logic [11:0]        x;
        logic [11:0]        y;
        logic signed [13:0] z;      // distance to the player, shrinks each tick
        color_t             color;
        dir_t               dir;
        logic [7:0]         id;
        logic               visible;
    } block_t;

    typedef block_t [NUM_SLOTS-1:0] slot_array_t;

    typedef struct packed {
        logic [7:0] id;
        logic       valid;
    } slice_slot_t;

    typedef slice_slot_t [NUM_SLOTS-1:0] slice_array_t;

    typedef struct packed {
        block_t     blk;
        logic [7:0] half_size;      // half edge length of the drawn square
    } sel_block_t;

endpackage

`default_nettype wire

// File: logic/block_window.sv
`timescale 1ns/100ps
`default_nettype none

module block_window (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      load,
    input  wire [3:0]                load_slot,
    input  wire rhythm_pkg::block_t  load_block,
    input  wire                      tick,
    output rhythm_pkg::slot_array_t  slots
);

    // depth after one tick, one extra bit to catch the pass below zero
    logic [14:0] z_dec [rhythm_pkg::NUM_SLOTS];

    always_comb begin
        for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
            z_dec[i] = {slots[i].z[13], slots[i].z} - 15'(rhythm_pkg::Z_STEP);
        end
    end

    // Each slot either takes a fresh block from the beat-map loader or,
    // on a tick, moves one step toward the player. A block that would go
    // behind the player is dropped from the window.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
                slots[i].visible <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
                if (load && load_slot == 4'(i)) begin
                    slots[i] <= load_block;         // load has priority over tick
                end else if (tick && slots[i].visible) begin
                    if (z_dec[i][14]) begin
                        slots[i].visible <= 1'b0;   // missed
                    end else begin
                        slots[i].z <= z_dec[i][13:0];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/slice_register.sv
`timescale 1ns/100ps
`default_nettype none

module slice_register (
    input  wire                       clk_in,
    input  wire                       rst_in,
    input  wire                       slice,
    input  wire [7:0]                 slice_id,
    output rhythm_pkg::slice_array_t  sliced
);

    logic [3:0] wr_ptr;     // next entry to fill, oldest once all are used
    logic [3:0] ptr_next;

    always_comb begin
        if (wr_ptr == 4'(rhythm_pkg::NUM_SLOTS - 1)) begin
            ptr_next = 4'd0;
        end else begin
            ptr_next = wr_ptr + 4'd1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= 4'd0;
            for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
                sliced[i].valid <= 1'b0;    // ids stay as they are
            end
        end else if (slice) begin
            sliced[wr_ptr].id    <= slice_id;
            sliced[wr_ptr].valid <= 1'b1;
            wr_ptr               <= ptr_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/block_selector.sv
`timescale 1ns/100ps
`default_nettype none

module block_selector (
    input  wire                            clk_in,
    input  wire                            rst_in,
    input  wire rhythm_pkg::pixel_t        pixel_in,
    input  wire rhythm_pkg::slot_array_t   slots,
    input  wire rhythm_pkg::slice_array_t  sliced,
    output rhythm_pkg::pixel_t             pixel_out,
    output rhythm_pkg::sel_block_t         sel
);

    // perspective size, 128 at z = 0 and shrinking with distance
    function automatic logic [7:0] calc_half_size(input logic signed [13:0] z);
        logic signed [24:0] prod;
        logic signed [24:0] size;
        prod = z * -25'sd502;
        size = 25'sd512 + (prod >>> 11);
        if (size > 25'sd512 || size < 25'sd0) begin
            size = '0;      // too far away or behind the player
        end
        return size[9:2];
    endfunction

    // inclusive test for c - h <= p <= c + h without wrap
    function automatic logic in_span(input logic [11:0] p, input logic [11:0] c,
                                     input logic [7:0] h);
        logic signed [13:0] d;
        logic signed [13:0] h_s;
        d   = $signed({2'b00, p}) - $signed({2'b00, c});
        h_s = $signed({6'b000000, h});
        return (d <= h_s) && (d >= -h_s);
    endfunction

    logic [rhythm_pkg::NUM_SLOTS-1:0] [7:0] half_size;
    logic [rhythm_pkg::NUM_SLOTS-1:0]       is_sliced;
    logic [rhythm_pkg::NUM_SLOTS-1:0]       covers;
    rhythm_pkg::sel_block_t                 sel_next;

    always_comb begin
        for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
            half_size[i] = calc_half_size(slots[i].z);
            is_sliced[i] = 1'b0;
            for (int j = 0; j < rhythm_pkg::NUM_SLOTS; j++) begin
                if (sliced[j].valid && sliced[j].id == slots[i].id) begin
                    is_sliced[i] = 1'b1;
                end
            end
            covers[i] = slots[i].visible && !is_sliced[i]
                     && in_span({1'b0, pixel_in.x}, slots[i].x, half_size[i])
                     && in_span({2'b00, pixel_in.y}, slots[i].y, half_size[i]);
        end
    end

    // scanning downward leaves the lowest covering slot as the winner
    always_comb begin
        sel_next = '0;
        for (int i = rhythm_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (covers[i]) begin
                sel_next.blk       = slots[i];
                sel_next.half_size = half_size[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pixel_out <= '0;
            sel       <= '0;
        end else begin
            pixel_out <= pixel_in;
            sel       <= sel_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/block_shader.sv
`timescale 1ns/100ps
`default_nettype none

module block_shader (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire rhythm_pkg::pixel_t      pixel_in,
    input  wire rhythm_pkg::sel_block_t  sel,
    output rhythm_pkg::pixel_t           pixel_out,
    output logic [11:0]                  rgb_out
);

    function automatic logic [13:0] mag(input logic signed [13:0] d);
        return (d < 14'sd0) ? -d : d;
    endfunction

    logic signed [13:0] dx;         // pixel offset from the block center
    logic signed [13:0] dy;
    logic signed [13:0] q_s;        // half_size / 2
    logic [13:0]        r;          // half_size / 4, radius of the center dot
    logic               in_marker;
    logic [11:0]        rgb_next;

    always_comb begin
        dx  = $signed({3'b000, pixel_in.x}) - $signed({2'b00, sel.blk.x});
        dy  = $signed({4'b0000, pixel_in.y}) - $signed({2'b00, sel.blk.y});
        q_s = $signed({7'b0000000, sel.half_size[7:1]});
        r   = {8'b00000000, sel.half_size[7:2]};

        // the marker sits on the edge the player has to cut toward
        case (sel.blk.dir)
            rhythm_pkg::dir_up:    in_marker = dy <= -q_s;
            rhythm_pkg::dir_down:  in_marker = dy >= q_s;
            rhythm_pkg::dir_left:  in_marker = dx <= -q_s;
            rhythm_pkg::dir_right: in_marker = dx >= q_s;
            rhythm_pkg::dir_any:   in_marker = (mag(dx) <= r) && (mag(dy) <= r);
            default:               in_marker = 1'b0;
        endcase

        if (!sel.blk.visible) begin
            rgb_next = rhythm_pkg::BG_COLOR;
        end else if (in_marker) begin
            rgb_next = rhythm_pkg::MARK_RGB;
        end else if (sel.blk.color == rhythm_pkg::color_red) begin
            rgb_next = rhythm_pkg::RED_RGB;
        end else begin
            rgb_next = rhythm_pkg::BLUE_RGB;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pixel_out <= '0;
            rgb_out   <= rhythm_pkg::BG_COLOR;
        end else begin
            pixel_out <= pixel_in;
            rgb_out   <= rgb_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/render_top.sv
`timescale 1ns/100ps
`default_nettype none

module render_top (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire rhythm_pkg::pixel_t  pixel_in,
    input  wire                      load,
    input  wire [3:0]                load_slot,
    input  wire rhythm_pkg::block_t  load_block,
    input  wire                      tick,
    input  wire                      slice,
    input  wire [7:0]                slice_id,
    output rhythm_pkg::pixel_t       pixel_out,
    output logic [11:0]              rgb_out
);

    rhythm_pkg::slot_array_t   slots;
    rhythm_pkg::slice_array_t  sliced;
    rhythm_pkg::pixel_t        pix_sel;     // pixel aligned with sel
    rhythm_pkg::sel_block_t    sel;

    block_window window_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .load       (load),
        .load_slot  (load_slot),
        .load_block (load_block),
        .tick       (tick),
        .slots      (slots)
    );

    slice_register slices_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .slice    (slice),
        .slice_id (slice_id),
        .sliced   (sliced)
    );

    block_selector selector_i (     // stage 1
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .pixel_in  (pixel_in),
        .slots     (slots),
        .sliced    (sliced),
        .pixel_out (pix_sel),
        .sel       (sel)
    );

    block_shader shader_i (         // stage 2
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .pixel_in  (pix_sel),
        .sel       (sel),
        .pixel_out (pixel_out),
        .rgb_out   (rgb_out)
    );

endmodule

`default_nettype wire

// File: tb/render_tb_tasks.svh
`ifndef RENDER_TB_TASKS_SVH
`define RENDER_TB_TASKS_SVH

function automatic int magnitude(input int v);
    return (v < 0) ? -v : v;
endfunction

// perspective size from depth, then divided by 4
function automatic int half_size_of(input logic signed [13:0] z);
    int s;
    s = 512 + ((int'(z) * -502) >>> 11);
    if (s > 512) begin
        s = 0;
    end
    return s >> 2;
endfunction

function automatic logic [11:0] expected_rgb(input rhythm_pkg::pixel_t p);
    rhythm_pkg::block_t b;
    logic hit;
    logic cut;
    logic mark;
    int   h;
    int   hs;
    int   dx;
    int   dy;
    hit = 1'b0;
    b   = '0;
    hs  = 0;
    for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
        cut = 1'b0;
        for (int j = 0; j < rhythm_pkg::NUM_SLOTS; j++) begin
            cut = cut | (model_vld[j] && model_id[j] == model_slot[i].id);
        end
        h  = half_size_of(model_slot[i].z);
        dx = int'(p.x) - int'(model_slot[i].x);
        dy = int'(p.y) - int'(model_slot[i].y);
        if (!hit && model_slot[i].visible && !cut
                && magnitude(dx) <= h && magnitude(dy) <= h) begin
            hit = 1'b1;     // first covering slot wins
            b   = model_slot[i];
            hs  = h;
        end
    end
    if (!hit) begin
        return rhythm_pkg::BG_COLOR;
    end
    dx = int'(p.x) - int'(b.x);
    dy = int'(p.y) - int'(b.y);
    case (b.dir)
        rhythm_pkg::dir_up:    mark = int'(p.y) <= int'(b.y) - hs / 2;
        rhythm_pkg::dir_down:  mark = int'(p.y) >= int'(b.y) + hs / 2;
        rhythm_pkg::dir_left:  mark = int'(p.x) <= int'(b.x) - hs / 2;
        rhythm_pkg::dir_right: mark = int'(p.x) >= int'(b.x) + hs / 2;
        rhythm_pkg::dir_any:   mark = magnitude(dx) <= hs / 4 && magnitude(dy) <= hs / 4;
        default:               mark = 1'b0;
    endcase
    if (mark) begin
        return rhythm_pkg::MARK_RGB;
    end
    return (b.color == rhythm_pkg::color_red) ? rhythm_pkg::RED_RGB : rhythm_pkg::BLUE_RGB;
endfunction

task automatic check_pixel(input string name, input rhythm_pkg::pixel_t got,
                           input rhythm_pkg::pixel_t want);
    n_checks++;
    if (got !== want) begin
        n_errors++;
        $display("error %s: got %h, expected %h at %0t", name, got, want, $time);
    end
endtask

task automatic check_rgb(input string name, input logic [11:0] got, input logic [11:0] want);
    n_checks++;
    if (got !== want) begin
        n_errors++;
        $display("error %s: got %h, expected %h at %0t", name, got, want, $time);
    end
endtask

// one clock: check the pixel sent two cycles back, then send the next
task automatic drive_pixel(input rhythm_pkg::pixel_t p);
    @(negedge clk_in);
    if (exp_vld[1]) begin
        check_pixel("pixel_out", pixel_out, exp_pix[1]);
        check_rgb("rgb_out", rgb_out, exp_rgb[1]);
    end
    exp_pix[1] = exp_pix[0];
    exp_rgb[1] = exp_rgb[0];
    exp_vld[1] = exp_vld[0];
    load       = 1'b0;              // strobes last one cycle
    tick       = 1'b0;
    slice      = 1'b0;
    pixel_in   = p;
    exp_pix[0] = p;
    exp_rgb[0] = expected_rgb(p);   // model still holds the state before this edge
    exp_vld[0] = 1'b1;
endtask

function automatic rhythm_pkg::pixel_t pixel_near(input int cx, input int cy, input int span);
    rhythm_pkg::pixel_t p;
    p.game_time = 18'($urandom);
    p.x         = 11'(cx + int'($urandom_range(2 * span)) - span);
    p.y         = 10'(cy + int'($urandom_range(2 * span)) - span);
    return p;
endfunction

function automatic rhythm_pkg::block_t new_block(input int x, input int y, input int z,
                                                 input rhythm_pkg::color_t color,
                                                 input rhythm_pkg::dir_t dir, input int id);
    rhythm_pkg::block_t b;
    b.x       = 12'(x);
    b.y       = 12'(y);
    b.z       = 14'(z);
    b.color   = color;
    b.dir     = dir;
    b.id      = 8'(id);
    b.visible = 1'b1;
    return b;
endfunction

task automatic burst_around(input int cx, input int cy, input int span, input int n);
    for (int i = 0; i < n; i++) begin
        drive_pixel(pixel_near(cx, cy, span));
    end
endtask

task automatic put_block(input int slot, input rhythm_pkg::block_t blk);
    drive_pixel(pixel_near(1024, 512, 1023));
    load             = 1'b1;
    load_slot        = 4'(slot);
    load_block       = blk;
    model_slot[slot] = blk;
endtask

task automatic step_time();
    drive_pixel(pixel_near(1024, 512, 1023));
    tick = 1'b1;
    for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
        if (model_slot[i].visible && int'(model_slot[i].z) - rhythm_pkg::Z_STEP < 0) begin
            model_slot[i].visible = 1'b0;   // block passed the player
        end else if (model_slot[i].visible) begin
            model_slot[i].z = model_slot[i].z - 14'(rhythm_pkg::Z_STEP);
        end
    end
endtask

task automatic cut_block(input int id);
    drive_pixel(pixel_near(1024, 512, 1023));
    slice                = 1'b1;
    slice_id             = 8'(id);
    model_id[model_ptr]  = 8'(id);
    model_vld[model_ptr] = 1'b1;
    model_ptr            = (model_ptr + 1) % rhythm_pkg::NUM_SLOTS;
endtask

task automatic clear_window();
    for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
        put_block(i, '0);
    end
endtask

task automatic idle_stream();
    burst_around(1024, 512, 1023, 40);
endtask

task automatic block_shapes();
    int k;
    for (int i = 0; i < 4; i++) begin
        put_block(2 + 3 * i, new_block(300 + 500 * i, 500, 400 * i,
                  (i % 2 == 1) ? rhythm_pkg::color_red : rhythm_pkg::color_blue,
                  rhythm_pkg::dir_t'(3'(i)), i + 1));
    end
    put_block(7, new_block(1000, 850, 200, rhythm_pkg::color_red, rhythm_pkg::dir_any, 9));
    for (int n = 0; n < 160; n++) begin
        k = int'($urandom_range(3));
        drive_pixel(pixel_near(300 + 500 * k, 500, 140));
    end
    burst_around(1000, 850, 130, 60);
endtask

task automatic overlap_priority();
    clear_window();
    // higher slot goes in first so load order cannot decide
    put_block(6, new_block(1060, 520, 0, rhythm_pkg::color_blue, rhythm_pkg::dir_up, 21));
    put_block(3, new_block(1000, 500, 0, rhythm_pkg::color_red, rhythm_pkg::dir_left, 20));
    burst_around(1030, 510, 80, 150);
endtask

task automatic slice_memory();
    clear_window();
    put_block(0, new_block(400, 400, 100, rhythm_pkg::color_red, rhythm_pkg::dir_right, 30));
    put_block(1, new_block(1400, 400, 100, rhythm_pkg::color_blue, rhythm_pkg::dir_down, 31));
    cut_block(30);
    burst_around(400, 400, 130, 40);
    burst_around(1400, 400, 130, 40);
    for (int i = 0; i < 12; i++) begin
        cut_block(100 + i);     // the last one overwrites id 30
    end
    burst_around(400, 400, 130, 40);
endtask

task automatic depth_ticks();
    clear_window();
    put_block(4, new_block(600, 300, 40, rhythm_pkg::color_blue, rhythm_pkg::dir_any, 40));
    put_block(8, new_block(1500, 700, 600, rhythm_pkg::color_red, rhythm_pkg::dir_up, 41));
    for (int t = 0; t < 4; t++) begin
        burst_around(600, 300, 140, 30);
        burst_around(1500, 700, 120, 30);
        step_time();
    end
    burst_around(600, 300, 140, 30);
endtask

`endif

// File: tb/render_tb.sv
`timescale 1ns/100ps
`default_nettype none

module render_tb;

    logic               clk_in;
    logic               rst_in;
    rhythm_pkg::pixel_t pixel_in;
    logic               load;
    logic [3:0]         load_slot;
    rhythm_pkg::block_t load_block;
    logic               tick;
    logic               slice;
    logic [7:0]         slice_id;
    rhythm_pkg::pixel_t pixel_out;
    logic [11:0]        rgb_out;

    int   n_checks;
    int   n_errors;

    // what the window and the slice memory should hold
    rhythm_pkg::block_t model_slot [rhythm_pkg::NUM_SLOTS];
    logic [7:0]         model_id   [rhythm_pkg::NUM_SLOTS];
    logic               model_vld  [rhythm_pkg::NUM_SLOTS];
    int                 model_ptr;

    // [0] is the pixel just driven, [1] the one before
    rhythm_pkg::pixel_t exp_pix [2];
    logic [11:0]        exp_rgb [2];
    logic               exp_vld [2];

    render_top dut_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .pixel_in   (pixel_in),
        .load       (load),
        .load_slot  (load_slot),
        .load_block (load_block),
        .tick       (tick),
        .slice      (slice),
        .slice_id   (slice_id),
        .pixel_out  (pixel_out),
        .rgb_out    (rgb_out)
    );

    `include "render_tb_tasks.svh"

    always #2 clk_in = ~clk_in;

    initial begin
        clk_in     = 1'b0;
        rst_in     = 1'b1;
        pixel_in   = '0;
        load       = 1'b0;
        load_slot  = 4'd0;
        load_block = '0;
        tick       = 1'b0;
        slice      = 1'b0;
        slice_id   = 8'd0;
        n_checks   = 0;
        n_errors   = 0;
        model_ptr  = 0;
        for (int i = 0; i < rhythm_pkg::NUM_SLOTS; i++) begin
            model_slot[i] = '0;
            model_id[i]   = 8'd0;
            model_vld[i]  = 1'b0;
        end
        exp_vld[0] = 1'b0;
        exp_vld[1] = 1'b0;
        void'($urandom(32'h57a0_7095));
        repeat (8) @(negedge clk_in);

        // both pipeline stages hold their reset values
        check_pixel("pixel_out", pixel_out, '0);
        check_rgb("rgb_out", rgb_out, rhythm_pkg::BG_COLOR);
        rst_in = 1'b0;

        idle_stream();
        block_shapes();
        overlap_priority();
        slice_memory();
        depth_ticks();
        drive_pixel(pixel_near(1024, 512, 1023));   // drain the last two pixels
        drive_pixel(pixel_near(1024, 512, 1023));

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: render_top.f
+incdir+tb
logic/rhythm_pkg.sv
logic/block_window.sv
logic/slice_register.sv
logic/block_selector.sv
logic/block_shader.sv
logic/render_top.sv
tb/render_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module render_tb \
    -f render_top.f --Mdir obj_dir -o render_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/render_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$log"; then
    exit 1
fi
exit 0
